// File: Bender.yml
package:
  name: soc_bus

sources:
  - soc_map_pkg.sv
  - bus_types_pkg.sv
  - clint_timer.sv
  - uart_tx_port.sv
  - bus_arbiter.sv
  - soc_bus_top.sv
  - target: test
    files:
      - tb_soc_bus.sv

// File: bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                            clk,
  input  logic                            rst,
  // instruction fetch
  input  logic                            fetch_valid_i,
  input  bus_types_pkg::rd_req_t          fetch_req_i,
  output logic                            fetch_done_o,
  output logic [soc_map_pkg::DATA_W-1:0]  fetch_rdata_o,
  // load
  input  logic                            load_valid_i,
  input  bus_types_pkg::rd_req_t          load_req_i,
  output logic                            load_done_o,
  output logic [soc_map_pkg::DATA_W-1:0]  load_rdata_o,
  // store
  input  logic                            store_valid_i,
  input  bus_types_pkg::wr_req_t          store_req_i,
  output logic                            store_done_o,
  // axi master
  output bus_types_pkg::axi_ar_t          ar_o,
  output logic                            ar_valid_o,
  input  logic                            ar_ready_i,
  input  bus_types_pkg::axi_r_t           r_i,
  input  logic                            r_valid_i,
  output logic                            r_ready_o,
  output bus_types_pkg::axi_aw_t          aw_o,
  output logic                            aw_valid_o,
  input  logic                            aw_ready_i,
  output bus_types_pkg::axi_w_t           w_o,
  output logic                            w_valid_o,
  input  logic                            w_ready_i,
  input  bus_types_pkg::axi_b_t           b_i,
  input  logic                            b_valid_i,
  output logic                            b_ready_o,
  // timer
  output logic                            timer_rd_en_o,
  output logic                            timer_hi_o,
  input  logic [soc_map_pkg::DATA_W-1:0]  timer_rdata_i,
  // uart
  output logic                            tx_valid_o,
  output logic [7:0]                      tx_byte_o,
  input  logic                            tx_accept_i
);
  import soc_map_pkg::*;
  import bus_types_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_axi_read_addr,
    st_axi_read_data,
    st_axi_write,
    st_timer_read,
    st_uart_write
  } state_t;

  typedef enum logic [1:0] {
    own_fetch,
    own_load,
    own_store
  } owner_t;

  state_t  state_q;
  owner_t  owner_q;
  logic    fetch_done_q;
  logic    load_done_q;
  logic    store_done_q;
  logic    aw_pend_q;
  logic    w_pend_q;
  logic    timer_src_q;
  wr_req_t req_q;
  logic [3:0]        id_q;
  logic [DATA_W-1:0] rdata_q;

  logic load_sel;
  logic store_sel;
  logic fetch_sel;
  logic timer_hit;
  logic serial_hit;
  logic r_hs;
  logic b_hs;

  // a requester still holding valid during its own done cycle is not reselected
  assign load_sel = load_valid_i && !load_done_q;
  assign store_sel = store_valid_i && !store_done_q;
  assign fetch_sel = fetch_valid_i && !fetch_done_q;

  assign timer_hit = (load_req_i.addr == TIMER_ADDR_LO) || (load_req_i.addr == TIMER_ADDR_HI);
  assign serial_hit = (store_req_i.addr == SERIAL_ADDR);

  assign r_hs = r_valid_i && r_ready_o && (r_i.id == id_q);
  assign b_hs = b_valid_i && b_ready_o && (b_i.id == id_q);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= st_idle;
      owner_q <= own_fetch;
      fetch_done_q <= 1'b0;
      load_done_q <= 1'b0;
      store_done_q <= 1'b0;
      aw_pend_q <= 1'b0;
      w_pend_q <= 1'b0;
      timer_src_q <= 1'b0;
    end
    else
    begin
      fetch_done_q <= 1'b0;
      load_done_q <= 1'b0;
      store_done_q <= 1'b0;
      case (state_q)
        st_idle:
        begin
          // load first, then store, then fetch
          if (load_sel)
          begin
            owner_q <= own_load;
            timer_src_q <= timer_hit;
            state_q <= timer_hit ? st_timer_read : st_axi_read_addr;
          end
          else if (store_sel)
          begin
            owner_q <= own_store;
            if (serial_hit)
            begin
              state_q <= st_uart_write;
            end
            else
            begin
              state_q <= st_axi_write;
              aw_pend_q <= 1'b1;
              w_pend_q <= 1'b1;
            end
          end
          else if (fetch_sel)
          begin
            owner_q <= own_fetch;
            timer_src_q <= 1'b0;
            state_q <= st_axi_read_addr;
          end
        end
        st_axi_read_addr:
        begin
          if (ar_ready_i)
          begin
            state_q <= st_axi_read_data;
          end
        end
        st_axi_read_data:
        begin
          if (r_hs)
          begin
            fetch_done_q <= (owner_q == own_fetch);
            load_done_q <= (owner_q == own_load);
            state_q <= st_idle;
          end
        end
        st_axi_write:
        begin
          // aw and w complete independently, b only after both
          if (aw_ready_i)
          begin
            aw_pend_q <= 1'b0;
          end
          if (w_ready_i)
          begin
            w_pend_q <= 1'b0;
          end
          if (b_hs)
          begin
            store_done_q <= 1'b1;
            state_q <= st_idle;
          end
        end
        st_timer_read:
        begin
          // timer data lands in the done cycle
          load_done_q <= 1'b1;
          state_q <= st_idle;
        end
        st_uart_write:
        begin
          if (tx_accept_i)
          begin
            store_done_q <= 1'b1;
            state_q <= st_idle;
          end
        end
        default:
        begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // request fields captured at selection
  always_ff @(posedge clk)
  begin
    if (state_q == st_idle)
    begin
      if (load_sel)
      begin
        req_q <= '{addr: load_req_i.addr, data: '0, strb: '0};
        id_q <= ID_MEM;
      end
      else if (store_sel)
      begin
        req_q <= store_req_i;
        id_q <= ID_MEM;
      end
      else if (fetch_sel)
      begin
        req_q <= '{addr: fetch_req_i.addr, data: '0, strb: '0};
        id_q <= ID_FETCH;
      end
    end
    if (r_hs)
    begin
      rdata_q <= r_i.data[DATA_W-1:0];
    end
  end

  assign ar_o = '{addr: req_q.addr, id: id_q, len: AXI_LEN_SINGLE,
                  size: AXI_SIZE_4B, burst: AXI_BURST_INCR};
  assign aw_o = '{addr: req_q.addr, id: id_q, len: AXI_LEN_SINGLE,
                  size: AXI_SIZE_4B, burst: AXI_BURST_INCR};
  // data rides in the low half of the wide bus
  assign w_o = '{data: {{(AXI_DATA_W-DATA_W){1'b0}}, req_q.data},
                 strb: {{((AXI_DATA_W-DATA_W)/8){1'b0}}, req_q.strb},
                 last: 1'b1};

  assign ar_valid_o = (state_q == st_axi_read_addr);
  assign r_ready_o = (state_q == st_axi_read_data);
  assign aw_valid_o = (state_q == st_axi_write) && aw_pend_q;
  assign w_valid_o = (state_q == st_axi_write) && w_pend_q;
  assign b_ready_o = (state_q == st_axi_write) && !aw_pend_q && !w_pend_q;

  assign timer_rd_en_o = (state_q == st_timer_read);
  assign timer_hi_o = (req_q.addr == TIMER_ADDR_HI);

  assign tx_valid_o = (state_q == st_uart_write);
  assign tx_byte_o = req_q.data[7:0];

  assign fetch_done_o = fetch_done_q;
  assign load_done_o = load_done_q;
  assign store_done_o = store_done_q;
  assign fetch_rdata_o = rdata_q;
  assign load_rdata_o = timer_src_q ? timer_rdata_i : rdata_q;

endmodule

// File: bus_types_pkg.sv
package bus_types_pkg;

  // single beat encodings
  localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;
  localparam logic [2:0] AXI_SIZE_4B = 3'd2;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  typedef struct packed {
    logic [soc_map_pkg::ADDR_W-1:0] addr;
    logic [3:0]                     id;
    logic [7:0]                     len;
    logic [2:0]                     size;
    logic [1:0]                     burst;
  } axi_ar_t;

  typedef struct packed {
    logic [soc_map_pkg::ADDR_W-1:0] addr;
    logic [3:0]                     id;
    logic [7:0]                     len;
    logic [2:0]                     size;
    logic [1:0]                     burst;
  } axi_aw_t;

  typedef struct packed {
    logic [soc_map_pkg::AXI_DATA_W-1:0]   data;
    logic [soc_map_pkg::AXI_DATA_W/8-1:0] strb;
    logic                                 last;
  } axi_w_t;

  typedef struct packed {
    logic [soc_map_pkg::AXI_DATA_W-1:0] data;
    logic [3:0]                         id;
    logic [1:0]                         resp;
    logic                               last;
  } axi_r_t;

  typedef struct packed {
    logic [3:0] id;
    logic [1:0] resp;
  } axi_b_t;

  // requester side
  typedef struct packed {
    logic [soc_map_pkg::ADDR_W-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic [soc_map_pkg::ADDR_W-1:0]   addr;
    logic [soc_map_pkg::DATA_W-1:0]   data;
    logic [soc_map_pkg::DATA_W/8-1:0] strb;
  } wr_req_t;

endpackage

// File: clint_timer.sv
`timescale 1ns/1ps

module clint_timer (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           rd_en_i,
  input  logic                           hi_i,
  output logic [soc_map_pkg::DATA_W-1:0] rdata_o
);
  import soc_map_pkg::*;

  logic [7:0]  div_cnt_q;
  logic [63:0] mtime_q;
  logic        tick;
  logic [DATA_W-1:0] rdata_q;

  // one mtime step every MTIME_DIV clocks
  assign tick = (div_cnt_q == MTIME_DIV - 8'd1);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      div_cnt_q <= 8'd0;
    end
    else if (tick)
    begin
      div_cnt_q <= 8'd0;
    end
    else
    begin
      div_cnt_q <= div_cnt_q + 8'd1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q <= 64'd0;
    end
    else if (tick)
    begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // snapshot of the half selected in the rd_en cycle
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      rdata_q <= hi_i ? mtime_q[63:32] : mtime_q[31:0];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           fetch_valid_i,
  input  bus_types_pkg::rd_req_t         fetch_req_i,
  output logic                           fetch_done_o,
  output logic [soc_map_pkg::DATA_W-1:0] fetch_rdata_o,
  input  logic                           load_valid_i,
  input  bus_types_pkg::rd_req_t         load_req_i,
  output logic                           load_done_o,
  output logic [soc_map_pkg::DATA_W-1:0] load_rdata_o,
  input  logic                           store_valid_i,
  input  bus_types_pkg::wr_req_t         store_req_i,
  output logic                           store_done_o,
  output bus_types_pkg::axi_ar_t         ar_o,
  output logic                           ar_valid_o,
  input  logic                           ar_ready_i,
  input  bus_types_pkg::axi_r_t          r_i,
  input  logic                           r_valid_i,
  output logic                           r_ready_o,
  output bus_types_pkg::axi_aw_t         aw_o,
  output logic                           aw_valid_o,
  input  logic                           aw_ready_i,
  output bus_types_pkg::axi_w_t          w_o,
  output logic                           w_valid_o,
  input  logic                           w_ready_i,
  input  bus_types_pkg::axi_b_t          b_i,
  input  logic                           b_valid_i,
  output logic                           b_ready_o,
  output logic                           uart_tx_o
);
  import soc_map_pkg::*;

  logic              timer_rd_en;
  logic              timer_hi;
  logic [DATA_W-1:0] timer_rdata;
  logic              tx_valid;
  logic [7:0]        tx_byte;
  logic              tx_accept;

  bus_arbiter arbiter_inst (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_done_o  (fetch_done_o),
    .fetch_rdata_o (fetch_rdata_o),
    .load_valid_i  (load_valid_i),
    .load_req_i    (load_req_i),
    .load_done_o   (load_done_o),
    .load_rdata_o  (load_rdata_o),
    .store_valid_i (store_valid_i),
    .store_req_i   (store_req_i),
    .store_done_o  (store_done_o),
    .ar_o          (ar_o),
    .ar_valid_o    (ar_valid_o),
    .ar_ready_i    (ar_ready_i),
    .r_i           (r_i),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .aw_o          (aw_o),
    .aw_valid_o    (aw_valid_o),
    .aw_ready_i    (aw_ready_i),
    .w_o           (w_o),
    .w_valid_o     (w_valid_o),
    .w_ready_i     (w_ready_i),
    .b_i           (b_i),
    .b_valid_i     (b_valid_i),
    .b_ready_o     (b_ready_o),
    .timer_rd_en_o (timer_rd_en),
    .timer_hi_o    (timer_hi),
    .timer_rdata_i (timer_rdata),
    .tx_valid_o    (tx_valid),
    .tx_byte_o     (tx_byte),
    .tx_accept_i   (tx_accept)
  );

  clint_timer timer_inst (
    .clk     (clk),
    .rst     (rst),
    .rd_en_i (timer_rd_en),
    .hi_i    (timer_hi),
    .rdata_o (timer_rdata)
  );

  uart_tx_port uart_inst (
    .clk         (clk),
    .rst         (rst),
    .tx_valid_i  (tx_valid),
    .tx_byte_i   (tx_byte),
    .tx_accept_o (tx_accept),
    .tx_o        (uart_tx_o)
  );

endmodule

// File: soc_map_pkg.sv
package soc_map_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int AXI_DATA_W = 64;

  // local device addresses, everything else goes out on AXI
  localparam logic [ADDR_W-1:0] TIMER_ADDR_LO = 32'ha000_0048;
  localparam logic [ADDR_W-1:0] TIMER_ADDR_HI = 32'ha000_004c;
  localparam logic [ADDR_W-1:0] SERIAL_ADDR = 32'ha000_03f8;

  // clocks per mtime tick
  localparam logic [7:0] MTIME_DIV = 8'd4;

  // clocks per serial bit
  localparam logic [15:0] UART_DIV = 16'd16;

  // axi ids per requester class
  localparam logic [3:0] ID_FETCH = 4'd0;
  localparam logic [3:0] ID_MEM = 4'd1;

endpackage

// File: tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;
  import soc_map_pkg::*;
  import bus_types_pkg::*;

  typedef enum logic [1:0] {
    done_fetch,
    done_load,
    done_store
  } done_kind_t;

  typedef struct packed {
    done_kind_t  kind;
    logic [31:0] data;
  } exp_t;

  logic        clk;
  logic        rst;
  logic        fetch_valid;
  rd_req_t     fetch_req;
  logic        fetch_done;
  logic [31:0] fetch_rdata;
  logic        load_valid;
  rd_req_t     load_req;
  logic        load_done;
  logic [31:0] load_rdata;
  logic        store_valid;
  wr_req_t     store_req;
  logic        store_done;
  axi_ar_t     ar;
  logic        ar_valid;
  logic        ar_ready;
  axi_r_t      r;
  logic        r_valid;
  logic        r_ready;
  axi_aw_t     aw;
  logic        aw_valid;
  logic        aw_ready;
  axi_w_t      w;
  logic        w_valid;
  logic        w_ready;
  axi_b_t      b;
  logic        b_valid;
  logic        b_ready;
  logic        uart_tx;

  int          cyc;
  int          ar_count;
  int          aw_count;
  logic [31:0] lfsr_state = 32'he797_ea14;
  exp_t        exp_q[$];
  logic [9:0]  rx_frames[$];
  // slave memory and the expected contents
  logic [31:0] mem[logic [31:0]];
  logic [31:0] ref_mem[logic [31:0]];

  soc_bus_top soc_bus_top_inst (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid),
    .fetch_req_i   (fetch_req),
    .fetch_done_o  (fetch_done),
    .fetch_rdata_o (fetch_rdata),
    .load_valid_i  (load_valid),
    .load_req_i    (load_req),
    .load_done_o   (load_done),
    .load_rdata_o  (load_rdata),
    .store_valid_i (store_valid),
    .store_req_i   (store_req),
    .store_done_o  (store_done),
    .ar_o          (ar),
    .ar_valid_o    (ar_valid),
    .ar_ready_i    (ar_ready),
    .r_i           (r),
    .r_valid_i     (r_valid),
    .r_ready_o     (r_ready),
    .aw_o          (aw),
    .aw_valid_o    (aw_valid),
    .aw_ready_i    (aw_ready),
    .w_o           (w),
    .w_valid_o     (w_valid),
    .w_ready_i     (w_ready),
    .b_i           (b),
    .b_valid_i     (b_valid),
    .b_ready_o     (b_ready),
    .uart_tx_o     (uart_tx)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // cycles since reset release
  always @(posedge clk)
  begin
    if (rst)
      cyc <= 0;
    else
      cyc <= cyc + 1;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else stop_on_error($sformatf("Error: %s expected %08h got %08h", name, expected, actual));
  endtask

  // galois lfsr, one step per bit
  function automatic int rand_bits(input int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      val = (val << 1) | lfsr_state[0];
    end
    return val;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    return mem.exists(addr) ? mem[addr] : fill_word(addr);
  endfunction

  function automatic logic [31:0] ref_read(input logic [31:0] addr);
    return ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
  endfunction

  // byte lanes with a set strobe take the new data
  function automatic logic [31:0] merge_word(input logic [31:0] old_word,
                                             input logic [31:0] data, input logic [3:0] strb);
    logic [31:0] word;
    word = old_word;
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i])
        word[8*i +: 8] = data[8*i +: 8];
    end
    return word;
  endfunction

  function automatic logic [63:0] ref_mtime(input int cycles);
    return 64'(cycles) / MTIME_DIV;
  endfunction

  // start bit in bit 0, stop bit in bit 9
  function automatic logic [9:0] serial_frame(input logic [7:0] data);
    return {1'b1, data, 1'b0};
  endfunction

  // fetch code sits in the 0x1xxx page, data in the 0x2xxx page
  function automatic logic [3:0] expected_id(input logic [31:0] addr);
    return (addr[15:12] == 4'h1) ? ID_FETCH : ID_MEM;
  endfunction

  function automatic void expect_done(input done_kind_t kind, input logic [31:0] data);
    exp_q.push_back('{kind: kind, data: data});
  endfunction

  task automatic check_addr_chan(input string chan, input logic [31:0] addr,
                                 input logic [3:0] id, input logic [7:0] len,
                                 input logic [2:0] size, input logic [1:0] burst);
    check_value({chan, ".id"}, expected_id(addr), id);
    check_value({chan, ".len"}, 0, len);
    check_value({chan, ".size"}, 2, size);
    check_value({chan, ".burst"}, 1, burst);
  endtask

  task automatic check_idle_outputs();
    check_value("ar_valid_o", 0, ar_valid);
    check_value("aw_valid_o", 0, aw_valid);
    check_value("w_valid_o", 0, w_valid);
    check_value("fetch_done_o", 0, fetch_done);
    check_value("load_done_o", 0, load_done);
    check_value("store_done_o", 0, store_done);
    check_value("uart_tx_o", 1, uart_tx);
  endtask

  // requester holds valid until its done pulse, then one idle cycle
  task automatic run_fetch(input logic [31:0] addr, output int done_cyc);
    fetch_req.addr = addr;
    fetch_valid = 1'b1;
    @(negedge clk);
    while (!fetch_done)
      @(negedge clk);
    done_cyc = cyc;
    fetch_valid = 1'b0;
    @(negedge clk);
  endtask

  task automatic run_load(input logic [31:0] addr, output int done_cyc);
    load_req.addr = addr;
    load_valid = 1'b1;
    @(negedge clk);
    while (!load_done)
      @(negedge clk);
    done_cyc = cyc;
    load_valid = 1'b0;
    @(negedge clk);
  endtask

  task automatic run_store(input wr_req_t req, output int done_cyc);
    store_req = req;
    store_valid = 1'b1;
    @(negedge clk);
    while (!store_done)
      @(negedge clk);
    done_cyc = cyc;
    store_valid = 1'b0;
    @(negedge clk);
  endtask

  task automatic axi_store(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    wr_req_t req;
    int      dc;
    req.addr = addr;
    req.data = data;
    req.strb = strb;
    ref_mem[addr] = merge_word(ref_read(addr), data, strb);
    expect_done(done_store, 32'h0);
    run_store(req, dc);
  endtask

  task automatic axi_load(input logic [31:0] addr);
    int dc;
    expect_done(done_load, ref_read(addr));
    run_load(addr, dc);
  endtask

  task automatic axi_fetch(input logic [31:0] addr);
    int dc;
    expect_done(done_fetch, ref_read(addr));
    run_fetch(addr, dc);
  endtask

  // every done pulse must match the oldest pending request
  always @(negedge clk)
  begin : compare_done
    exp_t front;
    if (!rst && (fetch_done || load_done || store_done))
    begin
      assert (exp_q.size() != 0)
      else stop_on_error("a done pulse came with no request pending");
      front = exp_q.pop_front();
      check_value("fetch_done_o", front.kind == done_fetch, fetch_done);
      check_value("load_done_o", front.kind == done_load, load_done);
      check_value("store_done_o", front.kind == done_store, store_done);
      if (front.kind == done_fetch)
        check_value("fetch_rdata_o", front.data, fetch_rdata);
      else if (front.kind == done_load)
        check_value("load_rdata_o", front.data, load_rdata);
    end
  end

  // single beat read slave with random delays
  initial
  begin : axi_read_slave
    axi_ar_t     ar_seen;
    logic [31:0] word;
    forever
    begin
      @(negedge clk);
      if (!rst && ar_valid)
      begin
        ar_seen = ar;
        check_addr_chan("ar_o", ar_seen.addr, ar_seen.id, ar_seen.len, ar_seen.size,
                        ar_seen.burst);
        repeat (rand_bits(2))
        begin
          @(negedge clk);
          check_value("ar_valid_o", 1, ar_valid);
          check_value("ar_o.addr", ar_seen.addr, ar.addr);
        end
        ar_ready = 1'b1;
        @(negedge clk);
        ar_ready = 1'b0;
        ar_count++;
        check_value("ar_valid_o", 0, ar_valid);
        check_value("r_ready_o", 1, r_ready);
        repeat (rand_bits(2)) @(negedge clk);
        word = model_read(ar_seen.addr);
        // upper half carries junk the DUT must ignore
        r = '{data: {~word, word}, id: ar_seen.id, resp: 2'b00, last: 1'b1};
        r_valid = 1'b1;
        @(negedge clk);
        r_valid = 1'b0;
        check_value("fetch_done_o | load_done_o", 1, fetch_done | load_done);
      end
    end
  end

  // write slave, aw accepted before w
  initial
  begin : axi_write_slave
    axi_aw_t aw_seen;
    axi_w_t  w_seen;
    forever
    begin
      @(negedge clk);
      if (!rst && (aw_valid || w_valid))
      begin
        check_value("aw_valid_o", 1, aw_valid);
        check_value("w_valid_o", 1, w_valid);
        aw_seen = aw;
        w_seen = w;
        check_addr_chan("aw_o", aw_seen.addr, aw_seen.id, aw_seen.len, aw_seen.size,
                        aw_seen.burst);
        check_value("w_o.strb[7:4]", 0, w_seen.strb[7:4]);
        check_value("w_o.last", 1, w_seen.last);
        repeat (rand_bits(2))
        begin
          @(negedge clk);
          check_value("aw_valid_o", 1, aw_valid);
        end
        aw_ready = 1'b1;
        @(negedge clk);
        aw_ready = 1'b0;
        aw_count++;
        check_value("aw_valid_o", 0, aw_valid);
        check_value("w_valid_o", 1, w_valid);
        repeat (rand_bits(2))
        begin
          @(negedge clk);
          check_value("w_valid_o", 1, w_valid);
        end
        w_ready = 1'b1;
        @(negedge clk);
        w_ready = 1'b0;
        check_value("w_valid_o", 0, w_valid);
        check_value("b_ready_o", 1, b_ready);
        mem[aw_seen.addr] = merge_word(model_read(aw_seen.addr), w_seen.data[31:0],
                                       w_seen.strb[3:0]);
        repeat (rand_bits(2)) @(negedge clk);
        b = '{id: aw_seen.id, resp: 2'b00};
        b_valid = 1'b1;
        @(negedge clk);
        b_valid = 1'b0;
        check_value("store_done_o", 1, store_done);
      end
    end
  end

  // samples each serial bit near its middle
  initial
  begin : uart_monitor
    logic [9:0] frame;
    forever
    begin
      @(negedge clk);
      if (!rst && uart_tx === 1'b0)
      begin
        repeat (UART_DIV / 2) @(negedge clk);
        for (int i = 0; i < 10; i++)
        begin
          frame[i] = uart_tx;
          if (i < 9)
            repeat (UART_DIV) @(negedge clk);
        end
        rx_frames.push_back(frame);
      end
    end
  end

  initial
  begin : watchdog
    int limit;
    // 25 accesses and 2 serial bytes, plus slack
    limit = 25 * 20 + 2 * 10 * UART_DIV + 100;
    repeat (limit) @(posedge clk);
    stop_on_error("timeout: the test did not finish within the expected number of cycles");
  end

  initial
  begin : stimulus
    int          dc;
    int          dc1;
    int          dc2;
    int          c0;
    int          ar_before;
    int          aw_before;
    logic [63:0] mt;
    wr_req_t     sreq;
    rst = 1'b1;
    fetch_valid = 1'b0;
    fetch_req = '0;
    load_valid = 1'b0;
    load_req = '0;
    store_valid = 1'b0;
    store_req = '0;
    ar_ready = 1'b0;
    r = '0;
    r_valid = 1'b0;
    aw_ready = 1'b0;
    w_ready = 1'b0;
    b = '0;
    b_valid = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    check_idle_outputs();
    @(negedge clk);
    check_idle_outputs();

    // strobed stores merged, then read back
    axi_store(32'h0000_2000, 32'h1122_3344, 4'hf);
    axi_store(32'h0000_2004, 32'haabb_ccdd, 4'h5);
    axi_store(32'h0000_2000, 32'hdead_beef, 4'h6);
    axi_store(32'h0000_2008, 32'h0102_0304, 4'h8);
    axi_load(32'h0000_2000);
    axi_load(32'h0000_2004);
    axi_load(32'h0000_2008);

    for (int i = 0; i < 8; i++)
      axi_fetch(32'h0000_1000 + 4 * i);

    // same cycle fetch and load, load goes first
    for (int i = 0; i < 2; i++)
    begin
      expect_done(done_load, ref_read(32'h0000_2000 + 4 * i));
      expect_done(done_fetch, ref_read(32'h0000_1100 + 4 * i));
      fork
        run_load(32'h0000_2000 + 4 * i, dc1);
        run_fetch(32'h0000_1100 + 4 * i, dc2);
      join
    end

    // timer reads stay local with fixed latency
    ar_before = ar_count;
    for (int i = 0; i < 4; i++)
    begin
      repeat (i * 3) @(negedge clk);
      c0 = cyc;
      // rd_en is high in the cycle after selection
      mt = ref_mtime(c0 + 1);
      expect_done(done_load, i[0] ? mt[63:32] : mt[31:0]);
      run_load(i[0] ? TIMER_ADDR_HI : TIMER_ADDR_LO, dc);
      check_value("load_done_o latency", 2, dc - c0);
    end
    check_value("ar_valid_o handshake count", ar_before, ar_count);

    // two serial bytes back to back
    aw_before = aw_count;
    sreq.addr = SERIAL_ADDR;
    sreq.data = 32'h1234_56a5;
    sreq.strb = 4'h1;
    expect_done(done_store, 32'h0);
    run_store(sreq, dc1);
    sreq.data = 32'h89ab_cd3c;
    sreq.strb = 4'hf;
    expect_done(done_store, 32'h0);
    run_store(sreq, dc2);
    assert (dc2 - dc1 >= 10 * UART_DIV)
    else stop_on_error("the second serial store finished before the first frame was sent");
    while (rx_frames.size() < 2)
      @(negedge clk);
    check_value("uart_tx_o frame 0", serial_frame(8'ha5), rx_frames[0]);
    check_value("uart_tx_o frame 1", serial_frame(8'h3c), rx_frames[1]);
    check_value("aw_valid_o handshake count", aw_before, aw_count);

    assert (exp_q.size() == 0)
    else stop_on_error("a request ended without its done pulse being checked");
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: uart_tx_port.sv
`timescale 1ns/1ps

module uart_tx_port (
  input  logic       clk,
  input  logic       rst,
  input  logic       tx_valid_i,
  input  logic [7:0] tx_byte_i,
  output logic       tx_accept_o,
  output logic       tx_o
);
  import soc_map_pkg::*;

  logic        busy_q;
  logic [15:0] baud_cnt_q;
  logic [3:0]  bit_cnt_q;
  logic [9:0]  frame_q;
  logic        baud_tick;

  // only take a byte while the line is free
  assign tx_accept_o = tx_valid_i && !busy_q;

  assign baud_tick = busy_q && (baud_cnt_q == UART_DIV - 16'd1);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_q <= 1'b0;
      baud_cnt_q <= 16'd0;
      bit_cnt_q <= 4'd0;
      frame_q <= '1;
    end
    else if (tx_accept_o)
    begin
      // stop, data lsb first, start
      busy_q <= 1'b1;
      baud_cnt_q <= 16'd0;
      bit_cnt_q <= 4'd0;
      frame_q <= {1'b1, tx_byte_i, 1'b0};
    end
    else if (busy_q)
    begin
      if (baud_tick)
      begin
        baud_cnt_q <= 16'd0;
        // idle level shifts in behind the frame
        frame_q <= {1'b1, frame_q[9:1]};
        if (bit_cnt_q == 4'd9)
        begin
          busy_q <= 1'b0;
          bit_cnt_q <= 4'd0;
        end
        else
        begin
          bit_cnt_q <= bit_cnt_q + 4'd1;
        end
      end
      else
      begin
        baud_cnt_q <= baud_cnt_q + 16'd1;
      end
    end
  end

  assign tx_o = frame_q[0];

endmodule

// File: verilog.f
soc_map_pkg.sv
bus_types_pkg.sv
clint_timer.sv
uart_tx_port.sv
bus_arbiter.sv
soc_bus_top.sv
tb_soc_bus.sv
